/* source/bus_pkg.sv */
package bus_pkg;

  // ==================================================
  // bus widths
  // ==================================================
  typedef logic [31:0] addr_t;  // byte address.
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // all clear means load.

  typedef enum logic [1:0] {
    slot_ram   = 2'd0,
    slot_gpio  = 2'd1,
    slot_timer = 2'd2
  } slot_t;

  localparam int N_CORE    = 2;
  localparam int N_SLOT    = 3;
  localparam int RAM_WORDS = 256;

  // register offsets, address bits 3:2.
  localparam logic [1:0] GPIO_OUT_OFS   = 2'd0;
  localparam logic [1:0] GPIO_IN_OFS    = 2'd1;
  localparam logic [1:0] TIMER_CNT_OFS  = 2'd0;
  localparam logic [1:0] TIMER_CMP_OFS  = 2'd1;
  localparam logic [1:0] TIMER_FLAG_OFS = 2'd2;

  // unmapped space lands in the ram slot.
  function automatic slot_t decode_slot(input addr_t addr);
    case (addr[29:28])
      2'd1:    return slot_gpio;
      2'd2:    return slot_timer;
      default: return slot_ram;
    endcase
  endfunction

endpackage

/* source/bus_crossbar.sv */
module bus_crossbar (
  input  logic                                   clk,
  input  logic                                   nrst,
  // core side
  input  logic            [bus_pkg::N_CORE-1:0]  core_req,
  input  bus_pkg::addr_t  [bus_pkg::N_CORE-1:0]  core_addr,
  input  bus_pkg::strb_t  [bus_pkg::N_CORE-1:0]  core_wstrb,
  input  bus_pkg::data_t  [bus_pkg::N_CORE-1:0]  core_wdata,
  output logic            [bus_pkg::N_CORE-1:0]  core_gnt,
  output logic            [bus_pkg::N_CORE-1:0]  core_data_gnt,
  output bus_pkg::data_t  [bus_pkg::N_CORE-1:0]  core_rdata,
  // slave side
  output logic            [bus_pkg::N_SLOT-1:0]  slv_req,
  output bus_pkg::addr_t  [bus_pkg::N_SLOT-1:0]  slv_addr,
  output bus_pkg::strb_t  [bus_pkg::N_SLOT-1:0]  slv_wstrb,
  output bus_pkg::data_t  [bus_pkg::N_SLOT-1:0]  slv_wdata,
  input  logic            [bus_pkg::N_SLOT-1:0]  slv_gnt,
  input  logic            [bus_pkg::N_SLOT-1:0]  slv_data_gnt,
  input  bus_pkg::data_t  [bus_pkg::N_SLOT-1:0]  slv_rdata
);
  import bus_pkg::*;

  // ==================================================
  // per-core request slots
  // ==================================================
  logic  [N_CORE-1:0] req_valid;
  logic  [N_CORE-1:0] req_requested;  // accepted by the slave.
  logic  [N_CORE-1:0] req_filled;     // load data captured.
  addr_t [N_CORE-1:0] req_addr;
  strb_t [N_CORE-1:0] req_strb;
  data_t [N_CORE-1:0] req_data;       // store data, then load data.
  slot_t              req_slot [N_CORE];

  logic [N_CORE-1:0] capture;
  logic [N_CORE-1:0] is_store;
  logic [N_CORE-1:0] own;
  logic [N_CORE-1:0] accept;
  logic [N_CORE-1:0] data_hit;
  logic [N_CORE-1:0] done;

  // one-hot owner per slot.
  logic [N_SLOT-1:0][N_CORE-1:0] route;

  always_comb begin
    for (int c = 0; c < N_CORE; c++) begin
      req_slot[c] = decode_slot(req_addr[c]);
      capture[c]  = core_req[c] & ~req_valid[c];
      is_store[c] = |req_strb[c];
    end
  end

  // ==================================================
  // arbitration
  // ==================================================
  always_comb begin
    for (int s = 0; s < N_SLOT; s++) begin
      route[s] = '0;
      // lowest waiting core wins.
      for (int c = N_CORE - 1; c >= 0; c--) begin
        if (req_valid[c] && req_slot[c] == slot_t'(s)) begin
          route[s]    = '0;
          route[s][c] = 1'b1;
        end
      end
      // a core already accepted keeps the slot until its data returns.
      for (int c = 0; c < N_CORE; c++) begin
        if (req_valid[c] && req_requested[c] && req_slot[c] == slot_t'(s)) begin
          route[s]    = '0;
          route[s][c] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < N_CORE; c++) begin
      own[c]      = route[req_slot[c]][c];
      accept[c]   = req_valid[c] & ~req_requested[c] & own[c] & slv_gnt[req_slot[c]];
      data_hit[c] = req_requested[c] & ~req_filled[c] & own[c] &
                    slv_data_gnt[req_slot[c]];
      done[c]     = (accept[c] & is_store[c]) | req_filled[c];
    end
  end

  // ==================================================
  // slot state
  // ==================================================
  always_ff @(posedge clk) begin
    if (!nrst) begin
      req_valid     <= '0;
      req_requested <= '0;
      req_filled    <= '0;
    end else begin
      for (int c = 0; c < N_CORE; c++) begin
        if (capture[c]) begin
          req_valid[c] <= 1'b1;
        end else if (done[c]) begin
          req_valid[c]     <= 1'b0;
          req_requested[c] <= 1'b0;
          req_filled[c]    <= 1'b0;
        end else if (accept[c]) begin
          req_requested[c] <= 1'b1;
        end else if (data_hit[c]) begin
          req_filled[c] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < N_CORE; c++) begin
      if (capture[c]) begin
        req_addr[c] <= core_addr[c];
        req_strb[c] <= core_wstrb[c];
        req_data[c] <= core_wdata[c];
      end else if (data_hit[c]) begin
        req_data[c] <= slv_rdata[req_slot[c]];
      end
    end
  end

  // ==================================================
  // routing
  // ==================================================
  always_comb begin
    for (int s = 0; s < N_SLOT; s++) begin
      slv_req[s]   = 1'b0;
      slv_addr[s]  = '0;
      slv_wstrb[s] = '0;
      slv_wdata[s] = '0;
      for (int c = 0; c < N_CORE; c++) begin
        if (route[s][c]) begin
          slv_req[s]   = ~req_requested[c];
          slv_addr[s]  = req_addr[c];
          slv_wstrb[s] = req_strb[c];
          slv_wdata[s] = req_data[c];
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < N_CORE; c++) begin
      core_gnt[c]      = ~req_valid[c];
      core_data_gnt[c] = req_filled[c];
      core_rdata[c]    = req_filled[c] ? req_data[c] : '0;
    end
  end

endmodule

/* source/bus_ram.sv */
module bus_ram (
  input  logic           clk,
  input  logic           nrst,
  input  logic           req,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::strb_t wstrb,
  input  bus_pkg::data_t wdata,
  output logic           gnt,
  output logic           data_gnt,
  output bus_pkg::data_t rdata
);
  import bus_pkg::*;

  data_t mem [RAM_WORDS];

  logic [$clog2(RAM_WORDS)-1:0] word_idx;
  logic                         accepted;
  logic                         is_load;
  logic                         pending;  // load data owed.

  assign word_idx = addr[$clog2(RAM_WORDS)+1:2];
  assign accepted = req & gnt;
  assign is_load  = ~|wstrb;

  // ==================================================
  // handshake
  // ==================================================
  always_ff @(posedge clk) begin
    if (!nrst) begin
      pending <= 1'b0;
    end else begin
      pending <= accepted & is_load;
    end
  end

  assign gnt      = ~pending;
  assign data_gnt = pending;

  // ==================================================
  // storage
  // ==================================================
  always_ff @(posedge clk) begin
    if (accepted) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];  // byte merge.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accepted && is_load) begin
      rdata <= mem[word_idx];
    end
  end

endmodule

/* source/bus_gpio.sv */
module bus_gpio (
  input  logic           clk,
  input  logic           nrst,
  input  logic           req,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::strb_t wstrb,
  input  bus_pkg::data_t wdata,
  input  bus_pkg::data_t gpio_in,
  output logic           gnt,
  output logic           data_gnt,
  output bus_pkg::data_t rdata,
  output bus_pkg::data_t gpio_out
);
  import bus_pkg::*;

  data_t out_q;
  data_t in_meta_q;  // first sync stage.
  data_t in_sync_q;
  logic  accepted;
  logic  is_load;
  logic  pending;

  assign accepted = req & gnt;
  assign is_load  = ~|wstrb;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pending   <= 1'b0;
      out_q     <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      pending   <= accepted & is_load;
      in_meta_q <= gpio_in;
      in_sync_q <= in_meta_q;
      if (accepted && addr[3:2] == GPIO_OUT_OFS) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) out_q[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // read mux, one cycle.
  always_ff @(posedge clk) begin
    if (accepted && is_load) begin
      case (addr[3:2])
        GPIO_OUT_OFS: rdata <= out_q;
        GPIO_IN_OFS:  rdata <= in_sync_q;
        default:      rdata <= '0;
      endcase
    end
  end

  assign gnt      = ~pending;
  assign data_gnt = pending;
  assign gpio_out = out_q;

endmodule

/* source/bus_timer.sv */
module bus_timer (
  input  logic           clk,
  input  logic           nrst,
  input  logic           req,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::strb_t wstrb,
  input  bus_pkg::data_t wdata,
  output logic           gnt,
  output logic           data_gnt,
  output bus_pkg::data_t rdata,
  output logic           timer_match
);
  import bus_pkg::*;

  data_t cnt_q;
  data_t cmp_q;
  logic  flag_q;     // sticky match.
  logic  accepted;
  logic  is_load;
  logic  pending;
  logic  flag_clr;

  assign accepted = req & gnt;
  assign is_load  = ~|wstrb;
  assign flag_clr = accepted & ~is_load & (addr[3:2] == TIMER_FLAG_OFS);

  // ==================================================
  // counter and compare
  // ==================================================
  always_ff @(posedge clk) begin
    if (!nrst) begin
      pending <= 1'b0;
      cnt_q   <= '0;
      cmp_q   <= '1;  // far away after reset.
      flag_q  <= 1'b0;
    end else begin
      pending <= accepted & is_load;
      cnt_q   <= cnt_q + 1'b1;
      if (cnt_q == cmp_q) begin
        flag_q <= 1'b1;  // set beats clear.
      end else if (flag_clr) begin
        flag_q <= 1'b0;
      end
      if (accepted && addr[3:2] == TIMER_CMP_OFS) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) cmp_q[8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accepted && is_load) begin
      case (addr[3:2])
        TIMER_CNT_OFS:  rdata <= cnt_q;
        TIMER_CMP_OFS:  rdata <= cmp_q;
        TIMER_FLAG_OFS: rdata <= {31'd0, flag_q};
        default:        rdata <= '0;
      endcase
    end
  end

  assign gnt         = ~pending;
  assign data_gnt    = pending;
  assign timer_match = flag_q;

endmodule

/* source/bus_subsystem.sv */
module bus_subsystem (
  input  logic                                   clk,
  input  logic                                   nrst,
  input  logic            [bus_pkg::N_CORE-1:0]  core_req,
  input  bus_pkg::addr_t  [bus_pkg::N_CORE-1:0]  core_addr,
  input  bus_pkg::strb_t  [bus_pkg::N_CORE-1:0]  core_wstrb,
  input  bus_pkg::data_t  [bus_pkg::N_CORE-1:0]  core_wdata,
  output logic            [bus_pkg::N_CORE-1:0]  core_gnt,
  output logic            [bus_pkg::N_CORE-1:0]  core_data_gnt,
  output bus_pkg::data_t  [bus_pkg::N_CORE-1:0]  core_rdata,
  input  bus_pkg::data_t                         gpio_in,
  output bus_pkg::data_t                         gpio_out,
  output logic                                   timer_match
);
  import bus_pkg::*;

  logic  [N_SLOT-1:0] slv_req;
  addr_t [N_SLOT-1:0] slv_addr;
  strb_t [N_SLOT-1:0] slv_wstrb;
  data_t [N_SLOT-1:0] slv_wdata;
  logic  [N_SLOT-1:0] slv_gnt;
  logic  [N_SLOT-1:0] slv_data_gnt;
  data_t [N_SLOT-1:0] slv_rdata;

  bus_crossbar u_bus_crossbar (
    .clk          (clk),
    .nrst         (nrst),
    .core_req     (core_req),
    .core_addr    (core_addr),
    .core_wstrb   (core_wstrb),
    .core_wdata   (core_wdata),
    .core_gnt     (core_gnt),
    .core_data_gnt(core_data_gnt),
    .core_rdata   (core_rdata),
    .slv_req      (slv_req),
    .slv_addr     (slv_addr),
    .slv_wstrb    (slv_wstrb),
    .slv_wdata    (slv_wdata),
    .slv_gnt      (slv_gnt),
    .slv_data_gnt (slv_data_gnt),
    .slv_rdata    (slv_rdata)
  );

  // ==================================================
  // slaves, one per slot
  // ==================================================
  bus_ram u_bus_ram (
    .clk(clk), .nrst(nrst),
    .req(slv_req[slot_ram]), .addr(slv_addr[slot_ram]),
    .wstrb(slv_wstrb[slot_ram]), .wdata(slv_wdata[slot_ram]),
    .gnt(slv_gnt[slot_ram]), .data_gnt(slv_data_gnt[slot_ram]),
    .rdata(slv_rdata[slot_ram])
  );

  bus_gpio u_bus_gpio (
    .clk(clk), .nrst(nrst),
    .req(slv_req[slot_gpio]), .addr(slv_addr[slot_gpio]),
    .wstrb(slv_wstrb[slot_gpio]), .wdata(slv_wdata[slot_gpio]),
    .gpio_in(gpio_in),
    .gnt(slv_gnt[slot_gpio]), .data_gnt(slv_data_gnt[slot_gpio]),
    .rdata(slv_rdata[slot_gpio]), .gpio_out(gpio_out)
  );

  bus_timer u_bus_timer (
    .clk(clk), .nrst(nrst),
    .req(slv_req[slot_timer]), .addr(slv_addr[slot_timer]),
    .wstrb(slv_wstrb[slot_timer]), .wdata(slv_wdata[slot_timer]),
    .gnt(slv_gnt[slot_timer]), .data_gnt(slv_data_gnt[slot_timer]),
    .rdata(slv_rdata[slot_timer]), .timer_match(timer_match)
  );

endmodule

/* bench/tb_clock.sv */
module tb_clock (
  output logic clk,
  output logic nrst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 10;  // 20 ns clock.

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    nrst = 1'b0;
    repeat (2) @(posedge clk);
    nrst <= 1'b1;
  end

endmodule

/* bench/bus_checker.sv */
module bus_checker (
  input logic                                            clk,
  input logic                                            nrst,
  input logic [bus_pkg::N_CORE-1:0]                      core_req,
  input logic [bus_pkg::N_CORE-1:0]                      core_gnt,
  input logic [bus_pkg::N_CORE-1:0]                      core_data_gnt,
  input logic [bus_pkg::N_SLOT-1:0][bus_pkg::N_CORE-1:0] route,
  input logic [bus_pkg::N_SLOT-1:0]                      slv_req,
  input bus_pkg::strb_t [bus_pkg::N_SLOT-1:0]            slv_wstrb,
  input logic [bus_pkg::N_SLOT-1:0]                      slv_gnt,
  input logic [bus_pkg::N_SLOT-1:0]                      slv_data_gnt
);
  timeunit 1ns;
  timeprecision 1ps;
  import bus_pkg::*;

  // sticky status, one per assertion.
  logic gnt_failed   = 1'b0;
  logic dgnt_failed  = 1'b0;
  logic route_failed = 1'b0;
  logic reset_failed = 1'b0;

  logic [N_CORE-1:0] held_q;     // request in flight, seen from the ports.
  logic [N_CORE-1:0] store_acc;  // store taken by its slave.

  function automatic logic owner_kept(input logic [N_SLOT-1:0][N_CORE-1:0] now_r,
                                      input logic [N_SLOT-1:0][N_CORE-1:0] past_r,
                                      input logic [N_SLOT-1:0]             gnt);
    logic ok;
    ok = 1'b1;
    for (int s = 0; s < N_SLOT; s++) begin
      if (!gnt[s] && (!$onehot(now_r[s]) || now_r[s] != past_r[s])) ok = 1'b0;
    end
    return ok;
  endfunction

  // ==================================================
  // port-level slot model
  // ==================================================
  always_comb begin
    store_acc = '0;
    for (int s = 0; s < N_SLOT; s++) begin
      if (slv_req[s] && slv_gnt[s] && |slv_wstrb[s]) begin
        store_acc = store_acc | route[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      held_q <= '0;
    end else begin
      held_q <= (held_q & ~(store_acc | core_data_gnt)) | (core_req & core_gnt);
    end
  end

  // ==================================================
  // protocol properties
  // ==================================================
  gnt_tracks_slot: assert property (@(posedge clk) disable iff (!nrst)
    core_gnt == ~held_q)
    else begin
      $error("core_gnt does not follow the request slot");
      gnt_failed = 1'b1;
    end

  data_gnt_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
    (core_data_gnt & $past(core_data_gnt)) == '0)
    else begin
      $error("core_data_gnt held high for two cycles");
      dgnt_failed = 1'b1;
    end

  // a slave that owes load data keeps its one owner.
  route_owner_kept: assert property (@(posedge clk) disable iff (!nrst)
    owner_kept(route, $past(route), slv_gnt))
    else begin
      $error("slave owner changed while load data was owed");
      route_failed = 1'b1;
    end

  // outputs idle right after a reset edge.
  reset_outputs_idle: assert property (@(posedge clk)
    !nrst |=> (core_gnt == '1 && core_data_gnt == '0 && slv_req == '0 &&
               slv_gnt == '1 && slv_data_gnt == '0))
    else begin
      $error("bus outputs active after reset");
      reset_failed = 1'b1;
    end

endmodule

bind bus_crossbar bus_checker u_bus_checker (
  .clk          (clk),
  .nrst         (nrst),
  .core_req     (core_req),
  .core_gnt     (core_gnt),
  .core_data_gnt(core_data_gnt),
  .route        (route),
  .slv_req      (slv_req),
  .slv_wstrb    (slv_wstrb),
  .slv_gnt      (slv_gnt),
  .slv_data_gnt (slv_data_gnt)
);

/* bench/tb_top.sv */
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import bus_pkg::*;

  localparam int    TIMEOUT    = 200;  // edges per wait.
  localparam int    CLK_PERIOD = 20;
  localparam addr_t GPIO_BASE  = 32'h1000_0000;
  localparam addr_t TIMER_BASE = 32'h2000_0000;

  logic               clk;
  logic               nrst;
  logic  [N_CORE-1:0] core_req;
  addr_t [N_CORE-1:0] core_addr;
  strb_t [N_CORE-1:0] core_wstrb;
  data_t [N_CORE-1:0] core_wdata;
  logic  [N_CORE-1:0] core_gnt;
  logic  [N_CORE-1:0] core_data_gnt;
  data_t [N_CORE-1:0] core_rdata;
  data_t              gpio_in;
  data_t              gpio_out;
  logic               timer_match;

  data_t ram_model [RAM_WORDS];  // reference memory.
  data_t gpio_out_model;
  int    seed = 42753;
  logic  protocol_failed;

  tb_clock u_tb_clock (.clk(clk), .nrst(nrst));

  bus_subsystem u_bus_subsystem (
    .clk          (clk),
    .nrst         (nrst),
    .core_req     (core_req),
    .core_addr    (core_addr),
    .core_wstrb   (core_wstrb),
    .core_wdata   (core_wdata),
    .core_gnt     (core_gnt),
    .core_data_gnt(core_data_gnt),
    .core_rdata   (core_rdata),
    .gpio_in      (gpio_in),
    .gpio_out     (gpio_out),
    .timer_match  (timer_match)
  );

  assign protocol_failed = u_bus_subsystem.u_bus_crossbar.u_bus_checker.gnt_failed |
                           u_bus_subsystem.u_bus_crossbar.u_bus_checker.dgnt_failed |
                           u_bus_subsystem.u_bus_crossbar.u_bus_checker.route_failed |
                           u_bus_subsystem.u_bus_crossbar.u_bus_checker.reset_failed;

  // ==================================================
  // helpers
  // ==================================================
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    assert (actual === expected) else
      stop_with_error($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
  endtask

  task automatic check_at_least(input string name, input data_t minimum, input data_t actual);
    assert (actual >= minimum) else
      stop_with_error($sformatf("CHECK FAILED %s: expected at least %0d, actual %0d",
                                name, minimum, actual));
  endtask

  function automatic data_t rand_word();
    return $random(seed);
  endfunction

  // hi lands in bits 29:28, so 3 is unmapped.
  function automatic addr_t ram_addr(input logic [7:0] idx, input logic [1:0] hi);
    return {2'b00, hi, 18'd0, idx, 2'b00};
  endfunction

  function automatic addr_t reg_addr(input addr_t base, input logic [1:0] ofs);
    return base | {28'd0, ofs, 2'b00};
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // ==================================================
  // core drivers
  // ==================================================
  task automatic wait_gnt(input int c, output int edges);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      if (edges > TIMEOUT) stop_with_error($sformatf("core %0d waited too long for core_gnt", c));
    end while (!core_gnt[c]);
  endtask

  // returns at the capture edge.
  task automatic issue_request(input int c, input addr_t addr, input strb_t strb,
                               input data_t data);
    int edges;
    wait_gnt(c, edges);
    core_req[c]   <= 1'b1;
    core_addr[c]  <= addr;
    core_wstrb[c] <= strb;
    core_wdata[c] <= data;
    @(posedge clk);
    core_req[c] <= 1'b0;
  endtask

  task automatic do_store(input int c, input addr_t addr, input strb_t strb,
                          input data_t data, output int lat);
    int edges;
    issue_request(c, addr, strb, data);
    wait_gnt(c, edges);
    lat = edges - 1;  // edge where the slot cleared.
  endtask

  task automatic do_load(input int c, input addr_t addr, output data_t data, output int lat);
    int edges;
    issue_request(c, addr, 4'h0, 32'd0);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      if (edges > TIMEOUT) stop_with_error($sformatf("core %0d load data never returned", c));
    end while (!core_data_gnt[c]);
    data = core_rdata[c];
    lat  = edges - 1;
  endtask

  task automatic wait_reset();
    int edges;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      if (edges > TIMEOUT) stop_with_error("reset was never released");
    end while (!nrst);
  endtask

  // ==================================================
  // tests
  // ==================================================
  task automatic ram_single_test();
    logic [7:0] idx;
    data_t      wd;
    data_t      rd;
    int         lat;
    idx = 8'(rand_word());
    wd  = rand_word();
    do_store(0, ram_addr(idx, 2'd0), 4'hF, wd, lat);
    ram_model[idx] = wd;
    do_load(0, ram_addr(idx, 2'd0), rd, lat);
    check_value("ram_store_load", ram_model[idx], rd);
    wd = rand_word();
    do_store(0, ram_addr(idx, 2'd0), 4'b0101, wd, lat);
    ram_model[idx] = merge_bytes(ram_model[idx], wd, 4'b0101);
    do_load(0, ram_addr(idx, 2'd3), rd, lat);  // unmapped alias.
    check_value("ram_partial_merge", ram_model[idx], rd);
  endtask

  task automatic parallel_test();
    logic [7:0] ia;
    logic [7:0] ib;
    data_t      wa;
    data_t      wb;
    data_t      wg;
    data_t      rd0;
    data_t      rd1;
    data_t      rdg;
    int         lat0;
    int         lat1;
    ia = 8'(rand_word());
    ib = ia ^ 8'h80;
    wa = rand_word();
    wb = rand_word();
    wg = rand_word();
    ram_model[ia]  = wa;
    ram_model[ib]  = wb;
    gpio_out_model = wg;
    fork
      begin
        do_store(0, ram_addr(ia, 2'd0), 4'hF, wa, lat0);
        do_load(0, ram_addr(ia, 2'd0), rd0, lat0);
        check_value("parallel_core0_ram", ram_model[ia], rd0);
      end
      begin
        do_store(1, ram_addr(ib, 2'd0), 4'hF, wb, lat1);
        do_store(1, reg_addr(GPIO_BASE, GPIO_OUT_OFS), 4'hF, wg, lat1);
        do_load(1, ram_addr(ib, 2'd0), rd1, lat1);
        check_value("parallel_core1_ram", ram_model[ib], rd1);
        do_load(1, reg_addr(GPIO_BASE, GPIO_OUT_OFS), rdg, lat1);
        check_value("parallel_core1_gpio", gpio_out_model, rdg);
      end
    join
  endtask

  task automatic contention_test();
    logic [7:0] ia;
    logic [7:0] ib;
    data_t      rd0;
    data_t      rd1;
    int         lat0;
    int         lat1;
    time        done_at [N_CORE];
    ia = 8'(rand_word());
    ib = ia ^ 8'h01;
    ram_model[ia] = rand_word();
    ram_model[ib] = rand_word();
    fork
      do_store(0, ram_addr(ia, 2'd0), 4'hF, ram_model[ia], lat0);
      do_store(1, ram_addr(ib, 2'd0), 4'hF, ram_model[ib], lat1);
    join
    fork
      begin
        do_load(0, ram_addr(ia, 2'd0), rd0, lat0);
        done_at[0] = $time;
      end
      begin
        do_load(1, ram_addr(ib, 2'd0), rd1, lat1);
        done_at[1] = $time;
      end
    join
    check_value("contention_core0", ram_model[ia], rd0);
    check_value("contention_core1", ram_model[ib], rd1);
    check_value("contention_order", 32'd1, {31'd0, done_at[0] < done_at[1]});
    // core 1 already owns the ram when core 0 arrives.
    fork
      do_load(1, ram_addr(ib, 2'd0), rd1, lat1);
      begin
        @(posedge clk);
        do_load(0, ram_addr(ia, 2'd0), rd0, lat0);
      end
    join
    check_value("contention_late_core0", ram_model[ia], rd0);
    check_value("contention_owner_core1", ram_model[ib], rd1);
  endtask

  task automatic gpio_test();
    data_t wg;
    data_t vin;
    data_t rd;
    int    lat;
    wg = rand_word();
    do_store(0, reg_addr(GPIO_BASE, GPIO_OUT_OFS), 4'hF, wg, lat);
    gpio_out_model = wg;
    check_value("gpio_out_pins", gpio_out_model, gpio_out);
    vin = rand_word();
    @(posedge clk);
    gpio_in <= vin;
    repeat (3) @(posedge clk);  // synchronizer depth.
    do_load(1, reg_addr(GPIO_BASE, GPIO_IN_OFS), rd, lat);
    check_value("gpio_in_read", vin, rd);
  endtask

  task automatic timer_test();
    data_t c1;
    data_t c2;
    data_t rd;
    time   t1;
    time   t2;
    int    lat;
    int    edges;
    do_load(0, reg_addr(TIMER_BASE, TIMER_CNT_OFS), c1, lat);
    t1 = $time;
    do_store(0, reg_addr(TIMER_BASE, TIMER_CMP_OFS), 4'hF, c1 + 32'd40, lat);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      if (edges > TIMEOUT) stop_with_error("timer_match never rose after the compare write");
    end while (!timer_match);
    do_load(0, reg_addr(TIMER_BASE, TIMER_FLAG_OFS), rd, lat);
    check_value("timer_flag_set", 32'd1, rd);
    do_store(0, reg_addr(TIMER_BASE, TIMER_FLAG_OFS), 4'hF, rand_word(), lat);
    check_value("timer_match_cleared", 32'd0, {31'd0, timer_match});
    do_load(0, reg_addr(TIMER_BASE, TIMER_FLAG_OFS), rd, lat);
    check_value("timer_flag_cleared", 32'd0, rd);
    do_load(0, reg_addr(TIMER_BASE, TIMER_CNT_OFS), c2, lat);
    t2 = $time;
    check_at_least("timer_count_advance", c1 + data_t'((t2 - t1) / CLK_PERIOD), c2);
  endtask

  task automatic latency_test();
    logic [7:0] idx;
    data_t      wd;
    data_t      rd;
    int         lat;
    idx = 8'(rand_word());
    wd  = rand_word();
    do_store(1, ram_addr(idx, 2'd0), 4'hF, wd, lat);
    ram_model[idx] = wd;
    check_value("store_latency", 32'd1, lat);
    do_load(1, ram_addr(idx, 2'd0), rd, lat);
    check_value("load_latency", 32'd2, lat);
    check_value("latency_data", ram_model[idx], rd);
  endtask

  // ==================================================
  // sequence
  // ==================================================
  always @(posedge clk) begin
    if (protocol_failed) stop_with_error("a bus protocol assertion failed in the checker");
  end

  initial begin
    core_req   = '0;
    core_addr  = '0;
    core_wstrb = '0;
    core_wdata = '0;
    gpio_in    = '0;
    wait_reset();
    ram_single_test();
    parallel_test();
    contention_test();
    gpio_test();
    timer_test();
    latency_test();
    repeat (2) @(posedge clk);
    if (protocol_failed) begin
      stop_with_error("a bus protocol assertion failed in the checker");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* files.f */
source/bus_pkg.sv
source/bus_crossbar.sv
source/bus_ram.sv
source/bus_gpio.sv
source/bus_timer.sv
source/bus_subsystem.sv
bench/tb_clock.sv
bench/bus_checker.sv
bench/tb_top.sv

/* Makefile */
# Verilator build and run of the bus subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "TEST PASSED"; \
	else echo "TEST FAILED: simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
